// File: logic/kernel_ctrl_pkg.sv
`default_nettype none

package kernel_ctrl_pkg;

  //////////////////////////////////////////////////
  // Bus and register geometry
  //////////////////////////////////////////////////
  localparam int WORD_W     = 32;
  localparam int ARG_NUM    = 8;
  localparam int REG_IDX_LO = 2;  // Word addressed
  localparam int REG_IDX_W  = $clog2(ARG_NUM);

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [31:0]          addr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Kernel register map
  localparam reg_idx_t REG_CMD       = reg_idx_t'(0);
  localparam reg_idx_t REG_OPCODE    = reg_idx_t'(1);
  localparam reg_idx_t REG_DATA0     = reg_idx_t'(2);
  localparam reg_idx_t REG_DATA1     = reg_idx_t'(3);
  localparam reg_idx_t REG_DELAY     = reg_idx_t'(4);
  localparam reg_idx_t REG_WD_CLEAR  = reg_idx_t'(5);
  localparam reg_idx_t REG_WD_ENABLE = reg_idx_t'(6);

  localparam word_t CMD_RESET_VALUE = 32'hDEADBEEF;

  //////////////////////////////////////////////////
  // State machines
  //////////////////////////////////////////////////
  typedef enum logic {LAUNCH_IDLE, LAUNCH_COUNT} launch_state_t;

  typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

endpackage

`default_nettype wire

// File: logic/axil_reg_slave.sv
`timescale 1ns/1ns
`default_nettype none

module axil_reg_slave (
  input  wire logic                   clk,
  input  wire logic                   rstn,
  // Read address and data
  input  wire logic                   arvalid_i,
  input  wire kernel_ctrl_pkg::addr_t araddr_i,
  input  wire logic                   rready_i,
  // Write address, data and response
  input  wire logic                   awvalid_i,
  input  wire kernel_ctrl_pkg::addr_t awaddr_i,
  input  wire logic                   wvalid_i,
  input  wire kernel_ctrl_pkg::word_t wdata_i,
  input  wire logic                   bready_i,
  // Core status words
  input  wire kernel_ctrl_pkg::word_t state0_i,
  input  wire kernel_ctrl_pkg::word_t state1_i,
  input  wire kernel_ctrl_pkg::word_t state2_i,
  input  wire kernel_ctrl_pkg::word_t state3_i,
  output logic                        arready_o,
  output logic                        rvalid_o,
  output kernel_ctrl_pkg::word_t      rdata_o,
  output logic                        awready_o,
  output logic                        wready_o,
  output logic                        bvalid_o,
  output logic                        cmd_new_o,
  output kernel_ctrl_pkg::word_t      opcode_o,
  output kernel_ctrl_pkg::word_t      data0_o,
  output kernel_ctrl_pkg::word_t      data1_o,
  output kernel_ctrl_pkg::word_t      delay_o,
  output logic                        wd_clear_o,
  output logic                        wd_enable_o
);

  import kernel_ctrl_pkg::*;

  rd_state_t rd_state;
  reg_idx_t  rd_idx;
  word_t     rd_mux;
  word_t     rdata_q;

  logic      awready_q;
  logic      wready_q;
  logic      waddr_got;
  logic      wdata_got;
  logic      bvalid_q;
  logic      cmd_new_q;
  reg_idx_t  wr_idx;
  word_t     wr_data;

  word_t     kreg [ARG_NUM];

  //////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////
  assign rd_idx = araddr_i[REG_IDX_LO +: REG_IDX_W];

  always_comb begin
    case (rd_idx)
      REG_CMD:    rd_mux = kreg[REG_CMD];
      REG_OPCODE: rd_mux = state0_i;  // Status words sit behind 1..4
      REG_DATA0:  rd_mux = state1_i;
      REG_DATA1:  rd_mux = state2_i;
      REG_DELAY:  rd_mux = state3_i;
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE:
          if (arvalid_i) rd_state <= RD_RESP;
        RD_RESP:
          if (rready_i) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // Data captured with the address, held until taken
  always_ff @(posedge clk) begin
    if (rd_state == RD_IDLE && arvalid_i) begin
      rdata_q <= rd_mux;
    end
  end

  assign arready_o = (rd_state == RD_IDLE);
  assign rvalid_o  = (rd_state == RD_RESP);
  assign rdata_o   = rdata_q;

  //////////////////////////////////////////////////
  // Write channels
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      awready_q <= 1'b1;
      wready_q  <= 1'b1;
      waddr_got <= 1'b0;
      wdata_got <= 1'b0;
      bvalid_q  <= 1'b0;
      cmd_new_q <= 1'b0;
    end else begin
      cmd_new_q <= 1'b0;
      if (awready_q && awvalid_i) begin
        awready_q <= 1'b0;
        waddr_got <= 1'b1;
      end
      if (wready_q && wvalid_i) begin
        wready_q  <= 1'b0;
        wdata_got <= 1'b1;
      end
      if (waddr_got && wdata_got) begin
        waddr_got <= 1'b0;
        wdata_got <= 1'b0;
        bvalid_q  <= 1'b1;
        cmd_new_q <= (wr_idx == REG_CMD);
      end
      if (bvalid_q && bready_i) begin
        bvalid_q  <= 1'b0;
        awready_q <= 1'b1;  // Both channels reopen together
        wready_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awready_q && awvalid_i) wr_idx <= awaddr_i[REG_IDX_LO +: REG_IDX_W];
    if (wready_q && wvalid_i) wr_data <= wdata_i;
  end

  // Kernel registers
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < ARG_NUM; i++) begin
        kreg[i] <= '0;
      end
      kreg[REG_CMD] <= CMD_RESET_VALUE;
    end else if (waddr_got && wdata_got) begin
      case (wr_idx)
        REG_WD_CLEAR, REG_WD_ENABLE: kreg[wr_idx] <= word_t'(wr_data[0]);  // Flag bit only
        default:                     kreg[wr_idx] <= wr_data;
      endcase
    end
  end

  assign awready_o   = awready_q;
  assign wready_o    = wready_q;
  assign bvalid_o    = bvalid_q;
  assign cmd_new_o   = cmd_new_q;
  assign opcode_o    = kreg[REG_OPCODE];
  assign data0_o     = kreg[REG_DATA0];
  assign data1_o     = kreg[REG_DATA1];
  assign delay_o     = kreg[REG_DELAY];
  assign wd_clear_o  = kreg[REG_WD_CLEAR][0];
  assign wd_enable_o = kreg[REG_WD_ENABLE][0];

endmodule

`default_nettype wire

// File: logic/cmd_launcher.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_launcher (
  input  wire logic                   clk,
  input  wire logic                   rstn,
  input  wire logic                   cmd_new_i,
  input  wire kernel_ctrl_pkg::word_t delay_i,
  output logic                        cmd_valid_o
);

  import kernel_ctrl_pkg::*;

  launch_state_t state;
  word_t         cnt;

  //////////////////////////////////////////////////
  // Countdown FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= LAUNCH_IDLE;
    end else begin
      case (state)
        LAUNCH_IDLE:
          if (cmd_new_i) state <= LAUNCH_COUNT;
        LAUNCH_COUNT:
          if (cnt == '0) state <= LAUNCH_IDLE;
        default: state <= LAUNCH_IDLE;
      endcase
    end
  end

  // New commands while counting are dropped
  always_ff @(posedge clk) begin
    if (state == LAUNCH_IDLE) begin
      if (cmd_new_i) cnt <= delay_i;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // Strobe on the last counting cycle
  assign cmd_valid_o = (state == LAUNCH_COUNT) && (cnt == '0);

endmodule

`default_nettype wire

// File: logic/watchdog_reset.sv
`timescale 1ns/1ns
`default_nettype none

module watchdog_reset #(
  parameter int unsigned TIMEOUT_CYCLES = 150000000,
  parameter int unsigned PULSE_CYCLES   = 50000
) (
  input  wire logic clk,
  input  wire logic rstn,
  input  wire logic wd_clear_i,
  input  wire logic wd_enable_i,
  output logic      sys_reset_o
);

  localparam int CNT_W   = $clog2(TIMEOUT_CYCLES + 1);
  localparam int PULSE_W = $clog2(PULSE_CYCLES + 1);

  localparam logic [CNT_W-1:0]   CNT_LAST  = CNT_W'(TIMEOUT_CYCLES - 1);
  localparam logic [PULSE_W-1:0] PULSE_LEN = PULSE_W'(PULSE_CYCLES);

  logic [CNT_W-1:0]   count;
  logic [PULSE_W-1:0] pulse_left;
  logic               sys_reset_q;

  //////////////////////////////////////////////////
  // Timeout and pulse counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      count       <= '0;
      pulse_left  <= '0;
      sys_reset_q <= 1'b0;
    end else begin
      sys_reset_q <= (pulse_left != '0);
      if (pulse_left != '0) pulse_left <= pulse_left - 1'b1;

      if (wd_enable_i && !wd_clear_i) begin
        if (count == CNT_LAST) begin
          count      <= '0;
          pulse_left <= PULSE_LEN;  // Arm the reset pulse
        end else begin
          count <= count + 1'b1;
        end
      end else begin
        count <= '0;  // Held while cleared or disabled
      end
    end
  end

  assign sys_reset_o = sys_reset_q;

endmodule

`default_nettype wire

// File: logic/kernel_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module kernel_ctrl_top #(
  parameter int unsigned TIMEOUT_CYCLES = 150000000,
  parameter int unsigned PULSE_CYCLES   = 50000
) (
  input  wire logic                   clk,
  input  wire logic                   rstn,
  input  wire logic                   arvalid_i,
  input  wire kernel_ctrl_pkg::addr_t araddr_i,
  input  wire logic                   rready_i,
  input  wire logic                   awvalid_i,
  input  wire kernel_ctrl_pkg::addr_t awaddr_i,
  input  wire logic                   wvalid_i,
  input  wire kernel_ctrl_pkg::word_t wdata_i,
  input  wire logic                   bready_i,
  input  wire kernel_ctrl_pkg::word_t state0_i,
  input  wire kernel_ctrl_pkg::word_t state1_i,
  input  wire kernel_ctrl_pkg::word_t state2_i,
  input  wire kernel_ctrl_pkg::word_t state3_i,
  output logic                        arready_o,
  output logic                        rvalid_o,
  output kernel_ctrl_pkg::word_t      rdata_o,
  output logic                        awready_o,
  output logic                        wready_o,
  output logic                        bvalid_o,
  output logic                        cmd_valid_o,
  output kernel_ctrl_pkg::word_t      cmd_opcode_o,
  output kernel_ctrl_pkg::word_t      cmd_data0_o,
  output kernel_ctrl_pkg::word_t      cmd_data1_o,
  output logic                        sys_reset_o
);

  import kernel_ctrl_pkg::*;

  logic  cmd_new;
  word_t delay;
  logic  wd_clear;
  logic  wd_enable;

  //////////////////////////////////////////////////
  // Register slave, launcher and watchdog
  //////////////////////////////////////////////////
  axil_reg_slave axil_reg_slave_i (
    .clk         (clk),
    .rstn        (rstn),
    .arvalid_i   (arvalid_i),
    .araddr_i    (araddr_i),
    .rready_i    (rready_i),
    .awvalid_i   (awvalid_i),
    .awaddr_i    (awaddr_i),
    .wvalid_i    (wvalid_i),
    .wdata_i     (wdata_i),
    .bready_i    (bready_i),
    .state0_i    (state0_i),
    .state1_i    (state1_i),
    .state2_i    (state2_i),
    .state3_i    (state3_i),
    .arready_o   (arready_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .awready_o   (awready_o),
    .wready_o    (wready_o),
    .bvalid_o    (bvalid_o),
    .cmd_new_o   (cmd_new),
    .opcode_o    (cmd_opcode_o),  // Payload follows the registers
    .data0_o     (cmd_data0_o),
    .data1_o     (cmd_data1_o),
    .delay_o     (delay),
    .wd_clear_o  (wd_clear),
    .wd_enable_o (wd_enable)
  );

  cmd_launcher cmd_launcher_i (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_new_i   (cmd_new),
    .delay_i     (delay),
    .cmd_valid_o (cmd_valid_o)
  );

  watchdog_reset #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .PULSE_CYCLES   (PULSE_CYCLES)
  ) watchdog_reset_i (
    .clk         (clk),
    .rstn        (rstn),
    .wd_clear_i  (wd_clear),
    .wd_enable_i (wd_enable),
    .sys_reset_o (sys_reset_o)
  );

endmodule

`default_nettype wire

// File: test/kernel_ctrl_checker.sv
`timescale 1ns/1ns
`default_nettype none

module kernel_ctrl_checker (
  input wire logic                   clk,
  input wire logic                   rstn,
  input wire logic                   rvalid_i,
  input wire logic                   rready_i,
  input wire kernel_ctrl_pkg::word_t rdata_i,
  input wire logic                   bvalid_i,
  input wire logic                   bready_i,
  input wire logic                   cmd_valid_i,
  input wire logic                   sys_reset_i,
  input wire logic                   wd_enable_i
);

  int unsigned fail_count = 0;  // Assertion failures so far

  //////////////////////////////////////////////////
  // Bus response rules
  //////////////////////////////////////////////////
  rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin
      fail_count++;
      $error("Read response changed before rready_i");
    end

  bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      fail_count++;
      $error("bvalid_o dropped before bready_i");
    end

  // Launcher and watchdog pulses
  cmd_single: assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid_i |=> !cmd_valid_i)
    else begin
      fail_count++;
      $error("cmd_valid_o high for two cycles");
    end

  reset_needs_enable: assert property (@(posedge clk) disable iff (!rstn)
    $rose(sys_reset_i) |-> $past(wd_enable_i, 2))  // Armed two edges before the rise
    else begin
      fail_count++;
      $error("sys_reset_o rose while the watchdog was disabled");
    end

endmodule

bind kernel_ctrl_top kernel_ctrl_checker checker_i (
  .clk         (clk),
  .rstn        (rstn),
  .rvalid_i    (rvalid_o),
  .rready_i    (rready_i),
  .rdata_i     (rdata_o),
  .bvalid_i    (bvalid_o),
  .bready_i    (bready_i),
  .cmd_valid_i (cmd_valid_o),
  .sys_reset_i (sys_reset_o),
  .wd_enable_i (wd_enable)
);

`default_nettype wire

// File: test/kernel_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

module kernel_ctrl_tb;

  import kernel_ctrl_pkg::*;

  localparam int TIMEOUT = 40;
  localparam int PULSE   = 5;

  typedef enum {OP_WR, OP_RD, OP_CMD, OP_WDOG, OP_QUIET, OP_STALL} op_t;

  typedef struct {
    op_t   op;
    int    idx;
    word_t data;
    word_t exp;
  } entry_t;

  logic   clk = 1'b0;
  logic   rstn;
  logic   arvalid_i, rready_i, awvalid_i, wvalid_i, bready_i;
  addr_t  araddr_i, awaddr_i;
  word_t  wdata_i, state0_i, state1_i, state2_i, state3_i;
  logic   arready_o, rvalid_o, awready_o, wready_o, bvalid_o, cmd_valid_o, sys_reset_o;
  word_t  rdata_o, cmd_opcode_o, cmd_data0_o, cmd_data1_o;

  entry_t tbl [$];
  word_t  model [8];  // Last value written per index
  integer seed = 32'hf68f;
  int     cyc = 0;

  kernel_ctrl_top #(
    .TIMEOUT_CYCLES (TIMEOUT),
    .PULSE_CYCLES   (PULSE)
  ) kernel_ctrl_top_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // Checks and bus tasks
  //////////////////////////////////////////////////
  task automatic compare(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  function automatic void add_entry(op_t op, int idx, word_t data, word_t exp);
    tbl.push_back('{op, idx, data, exp});
  endfunction

  task automatic write_reg(input int idx, input word_t data, output int c_b);
    @(posedge clk);
    awvalid_i <= 1'b1;
    awaddr_i  <= addr_t'(idx * 4);
    wvalid_i  <= 1'b1;
    wdata_i   <= data;
    do @(negedge clk); while (!(awready_o && wready_o));
    @(posedge clk);  // Address and data taken on this edge
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    do @(negedge clk); while (!bvalid_o);
    c_b = cyc;  // First bvalid_o cycle
    model[idx] = data;
  endtask

  task automatic read_reg(input int idx, output word_t data);
    @(posedge clk);
    arvalid_i <= 1'b1;
    araddr_i  <= addr_t'(idx * 4);
    do @(negedge clk); while (!arready_o);
    @(posedge clk);
    arvalid_i <= 1'b0;
    do @(negedge clk); while (!rvalid_o);
    data = rdata_o;
  endtask

  task automatic check_cmd_strobe(input word_t data, input word_t exp);
    int c_b;
    int c_2;
    write_reg(0, data, c_b);
    write_reg(0, data + 1, c_2);  // Lands during the countdown
    do @(negedge clk); while (!cmd_valid_o);
    compare("cmd_valid_o delay", word_t'(cyc - c_b), exp);
    compare("cmd_opcode_o", cmd_opcode_o, model[1]);
    compare("cmd_data0_o", cmd_data0_o, model[2]);
    compare("cmd_data1_o", cmd_data1_o, model[3]);
    repeat (2 * exp) begin
      @(negedge clk);
      compare("cmd_valid_o", word_t'(cmd_valid_o), '0);
    end
  endtask

  task automatic check_watchdog(input int idx, input word_t data, input word_t exp);
    int c_b;
    int rise;
    int high;
    write_reg(idx, data, c_b);
    do @(negedge clk); while (!sys_reset_o);
    compare("sys_reset_o rise delay", word_t'(cyc - c_b), exp);
    rise = cyc;
    high = 0;
    while (sys_reset_o) begin
      high++;
      @(negedge clk);
    end
    compare("sys_reset_o pulse length", word_t'(high), word_t'(PULSE));
    do @(negedge clk); while (!sys_reset_o);
    compare("sys_reset_o period", word_t'(cyc - rise), word_t'(TIMEOUT));
  endtask

  task automatic check_quiet(input int n);
    logic prev;
    @(negedge clk);
    prev = sys_reset_o;  // A pulse in flight may still finish
    repeat (n) begin
      @(negedge clk);
      if (sys_reset_o && !prev) compare("sys_reset_o", word_t'(sys_reset_o), '0);
      prev = sys_reset_o;
    end
  endtask

  task automatic check_backpressure(input int idx, input int n, input word_t exp);
    word_t held;
    @(posedge clk);
    rready_i  <= 1'b0;
    bready_i  <= 1'b0;
    arvalid_i <= 1'b1;
    araddr_i  <= addr_t'(idx * 4);
    awvalid_i <= 1'b1;
    awaddr_i  <= addr_t'(7 * 4);
    wvalid_i  <= 1'b1;
    wdata_i   <= 32'h5A5A_0007;
    do @(negedge clk); while (!(arready_o && awready_o && wready_o));
    @(posedge clk);
    arvalid_i <= 1'b0;
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    do @(negedge clk); while (!(rvalid_o && bvalid_o));
    held = rdata_o;
    compare("rdata_o", held, exp);
    repeat (n) begin
      @(negedge clk);
      compare("rvalid_o", word_t'(rvalid_o), 32'd1);
      compare("bvalid_o", word_t'(bvalid_o), 32'd1);
      compare("rdata_o", rdata_o, held);
      compare("arready_o", word_t'(arready_o), '0);
      compare("awready_o", word_t'(awready_o), '0);
      compare("wready_o", word_t'(wready_o), '0);
    end
    @(posedge clk);
    rready_i <= 1'b1;
    bready_i <= 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    word_t  st [4];
    entry_t e;
    word_t  got;
    int     c_b;
    for (int i = 0; i < 4; i++) st[i] = $random(seed);
    rstn      <= 1'b0;
    arvalid_i <= 1'b0;
    araddr_i  <= '0;
    rready_i  <= 1'b1;
    awvalid_i <= 1'b0;
    awaddr_i  <= '0;
    wvalid_i  <= 1'b0;
    wdata_i   <= '0;
    bready_i  <= 1'b1;
    state0_i  <= st[0];
    state1_i  <= st[1];
    state2_i  <= st[2];
    state3_i  <= st[3];

    add_entry(OP_RD, 0, '0, 32'hDEAD_BEEF);
    for (int i = 1; i <= 4; i++) add_entry(OP_RD, i, '0, st[i-1]);
    add_entry(OP_RD, 5, '0, '0);
    add_entry(OP_RD, 7, '0, '0);
    add_entry(OP_WR, 0, 32'h1234_5678, '0);
    add_entry(OP_RD, 0, '0, 32'h1234_5678);
    add_entry(OP_WR, 1, 32'hA5A5_0001, '0);
    add_entry(OP_WR, 2, 32'hD0D0_0002, '0);
    add_entry(OP_WR, 3, 32'hD1D1_0003, '0);
    add_entry(OP_WR, 4, 32'd12, '0);
    add_entry(OP_CMD, 0, 32'hC0DE_0001, 32'd13);     // Delay 12 plus one
    add_entry(OP_STALL, 0, 32'd8, 32'hC0DE_0002);    // Second command write holds
    add_entry(OP_WDOG, 6, 32'd1, 32'(TIMEOUT + 1));
    add_entry(OP_WR, 6, 32'd0, '0);
    add_entry(OP_QUIET, 0, 32'd100, '0);
    add_entry(OP_WR, 5, 32'hFFFF_FFFF, '0);
    add_entry(OP_WR, 6, 32'd1, '0);
    add_entry(OP_QUIET, 0, 32'd100, '0);
    add_entry(OP_RD, 6, '0, '0);

    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    compare("rvalid_o", word_t'(rvalid_o), '0);
    compare("bvalid_o", word_t'(bvalid_o), '0);
    compare("cmd_valid_o", word_t'(cmd_valid_o), '0);
    compare("sys_reset_o", word_t'(sys_reset_o), '0);
    compare("arready_o", word_t'(arready_o), 32'd1);
    compare("awready_o", word_t'(awready_o), 32'd1);
    compare("wready_o", word_t'(wready_o), 32'd1);

    foreach (tbl[i]) begin
      e = tbl[i];
      case (e.op)
        OP_WR:    write_reg(e.idx, e.data, c_b);
        OP_RD: begin
          read_reg(e.idx, got);
          compare($sformatf("rdata_o[%0d]", e.idx), got, e.exp);
        end
        OP_CMD:   check_cmd_strobe(e.data, e.exp);
        OP_WDOG:  check_watchdog(e.idx, e.data, e.exp);
        OP_QUIET: check_quiet(e.data);
        default:  check_backpressure(e.idx, e.data, e.exp);
      endcase
    end
    if (kernel_ctrl_top_i.checker_i.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "Bound checker assertions failed");
    end
  end

  // Run limit scales with the table
  initial begin
    @(posedge rstn);
    repeat (tbl.size() * 100 + 400) @(posedge clk);
    $display("Timeout: the test sequence did not finish in time");
    $display("Simulation failed");
    $fatal(1, "Run limit reached");
  end

endmodule

`default_nettype wire

// File: kernel_ctrl_top.f
logic/kernel_ctrl_pkg.sv
logic/axil_reg_slave.sv
logic/cmd_launcher.sv
logic/watchdog_reset.sv
logic/kernel_ctrl_top.sv
test/kernel_ctrl_checker.sv
test/kernel_ctrl_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --assert --top-module kernel_ctrl_tb -f kernel_ctrl_top.f \
       -o kernel_ctrl_sim \
  && ./obj_dir/kernel_ctrl_sim | tee /dev/stderr | grep -q "Simulation passed" \
  && echo "run.sh: testbench reported success" \
  || { echo "run.sh: build or simulation failed"; exit 1; }
